/* mips_top.f */
rtl/mips_isa_pkg.sv
rtl/mips_cpu_pkg.sv
rtl/mips_control.sv
rtl/mips_alu.sv
rtl/mips_cpu.sv
rtl/mips_regfile.sv
rtl/mips_fetch.sv
rtl/mips_data_mem.sv
rtl/mips_top.sv
tests/mips_checker.sv
tests/mips_top_tb.sv

/* rtl/mips_alu.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_alu
  import mips_isa_pkg::*;
  import mips_cpu_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result,
  output logic    zero
);

  always_comb begin
    case (op)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      // signed compare
      ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/mips_control.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_control
  import mips_isa_pkg::*;
  import mips_cpu_pkg::*;
(
  input  opcode_t opcode,
  input  funct_t  funct,
  output ctrl_t   ctrl
);

  always_comb begin
    // unknown opcodes fall through as a no-op
    ctrl = '{mem_to_reg: 1'b0, mem_write: 1'b0, branch: 1'b0, alu_src: 1'b0,
             reg_dst: 1'b0, reg_write: 1'b0, alu_op: ALU_AND};
    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (funct)
          FN_ADD:  ctrl.alu_op = ALU_ADD;
          FN_SUB:  ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          // unsupported funct, no writeback
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_LW: begin
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.alu_op     = ALU_ADD;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      OP_BEQ: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;
      end
      OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/mips_cpu.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_cpu
  import mips_isa_pkg::*;
  import mips_cpu_pkg::*;
(
  input  logic      run,
  input  word_t     pc,
  input  word_t     instr,
  output word_t     pc_next,
  output reg_addr_t ra1,
  output reg_addr_t ra2,
  input  word_t     rd1,
  input  word_t     rd2,
  output logic      reg_we,
  output reg_addr_t reg_wa,
  output word_t     reg_wd,
  output word_t     dmem_addr,
  output word_t     dmem_wdata,
  output logic      dmem_we,
  input  word_t     dmem_rdata,
  output retire_t   retire
);

  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  imm_t      imm;
  word_t     sign_imm;
  word_t     alu_b;
  word_t     alu_result;
  logic      alu_zero;
  word_t     pc_plus4;
  word_t     pc_branch;
  ctrl_t     ctrl;

  // instruction fields
  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = instr[15:0];
  assign funct  = instr[5:0];

  assign sign_imm = {{16{imm[15]}}, imm};

  mips_control u_control (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  assign ra1 = rs;
  assign ra2 = rt;

  // second operand is rt or the immediate
  assign alu_b = ctrl.alu_src ? sign_imm : rd2;

  mips_alu u_alu (
    .a      (rd1),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // writes only happen while the core runs
  assign reg_we = run & ctrl.reg_write;
  assign reg_wa = ctrl.reg_dst ? rd : rt;
  assign reg_wd = ctrl.mem_to_reg ? dmem_rdata : alu_result;

  assign dmem_addr  = alu_result;
  assign dmem_wdata = rd2;
  assign dmem_we    = run & ctrl.mem_write;

  // next pc
  assign pc_plus4  = pc + 32'd4;
  assign pc_branch = pc_plus4 + (sign_imm << 2);
  assign pc_next   = (ctrl.branch && alu_zero) ? pc_branch : pc_plus4;

  assign retire = '{pc: pc, instr: instr, reg_we: reg_we, reg_addr: reg_wa,
                    reg_data: reg_wd, mem_we: dmem_we, mem_addr: alu_result};

endmodule

`default_nettype wire

/* rtl/mips_cpu_pkg.sv */
`default_nettype none

package mips_cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // decoder outputs
  typedef struct packed {
    logic                  mem_to_reg;
    logic                  mem_write;
    logic                  branch;
    logic                  alu_src;
    logic                  reg_dst;
    logic                  reg_write;
    mips_isa_pkg::alu_op_t alu_op;
  } ctrl_t;

  // one record per executed instruction
  typedef struct packed {
    word_t     pc;
    word_t     instr;
    logic      reg_we;
    reg_addr_t reg_addr;
    word_t     reg_data;
    logic      mem_we;
    word_t     mem_addr;
  } retire_t;

endpackage

`default_nettype wire

/* rtl/mips_data_mem.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_data_mem
  import mips_cpu_pkg::*;
#(
  parameter int DMEM_WORDS = 64
) (
  input  logic  clk,
  input  word_t addr,
  input  word_t wdata,
  input  logic  we,
  output word_t rdata
);

  localparam int DMEM_AW = $clog2(DMEM_WORDS);

  word_t mem [DMEM_WORDS];
  logic [DMEM_AW-1:0] word_idx;

  // byte address to word index, wraps at the depth
  assign word_idx = addr[DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[word_idx] <= wdata;
    end
  end

  // lw sees the data in the same cycle
  assign rdata = mem[word_idx];

endmodule

`default_nettype wire

/* rtl/mips_fetch.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_fetch
  import mips_cpu_pkg::*;
#(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          run,
  input  word_t                         pc_next,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
  input  word_t                         imem_data,
  output word_t                         pc,
  output word_t                         instr
);

  localparam int IMEM_AW = $clog2(IMEM_WORDS);

  word_t imem [IMEM_WORDS];

  // pc holds while the core is stopped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc_next;
    end
  end

  // program load, only accepted when stopped
  always_ff @(posedge clk) begin
    if (imem_we && !run) begin
      imem[imem_addr] <= imem_data;
    end
  end

  // byte pc to word index, wraps at the depth
  assign instr = imem[pc[IMEM_AW+1:2]];

endmodule

`default_nettype wire

/* rtl/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

  // instruction field widths
  localparam int OPCODE_W = 6;
  localparam int FUNCT_W  = 6;
  localparam int IMM_W    = 16;

  typedef logic [OPCODE_W-1:0] opcode_t;
  typedef logic [FUNCT_W-1:0]  funct_t;
  typedef logic [IMM_W-1:0]    imm_t;

  // primary opcodes
  localparam opcode_t OP_RTYPE = 6'd0;
  localparam opcode_t OP_BEQ   = 6'd4;
  localparam opcode_t OP_ADDI  = 6'd8;
  localparam opcode_t OP_LW    = 6'd35;
  localparam opcode_t OP_SW    = 6'd43;

  // r-type function codes
  localparam funct_t FN_ADD = 6'd32;
  localparam funct_t FN_SUB = 6'd34;
  localparam funct_t FN_AND = 6'd36;
  localparam funct_t FN_OR  = 6'd37;
  localparam funct_t FN_SLT = 6'd42;

  // alu control encoding, matches the classic textbook table
  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } alu_op_t;

endpackage

`default_nettype wire

/* rtl/mips_regfile.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_regfile
  import mips_cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t dbg_addr,
  output word_t     rd1,
  output word_t     rd2,
  output word_t     dbg_data,
  input  logic      we,
  input  reg_addr_t wa,
  input  word_t     wd
);

  // r0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  assign rd1      = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2      = (ra2 == '0) ? '0 : regs[ra2];
  assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

/* rtl/mips_top.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_top
  import mips_cpu_pkg::*;
#(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          run,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
  input  word_t                         imem_data,
  input  reg_addr_t                     dbg_addr,
  output word_t                         dbg_data,
  output logic                          retire_valid,
  output retire_t                       retire
);

  word_t     pc;
  word_t     pc_next;
  word_t     instr;
  reg_addr_t ra1;
  reg_addr_t ra2;
  word_t     rd1;
  word_t     rd2;
  logic      reg_we;
  reg_addr_t reg_wa;
  word_t     reg_wd;
  word_t     dmem_addr;
  word_t     dmem_wdata;
  word_t     dmem_rdata;
  logic      dmem_we;

  mips_fetch #(
    .IMEM_WORDS (IMEM_WORDS)
  ) u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .pc_next   (pc_next),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .pc        (pc),
    .instr     (instr)
  );

  mips_cpu u_cpu (
    .run        (run),
    .pc         (pc),
    .instr      (instr),
    .pc_next    (pc_next),
    .ra1        (ra1),
    .ra2        (ra2),
    .rd1        (rd1),
    .rd2        (rd2),
    .reg_we     (reg_we),
    .reg_wa     (reg_wa),
    .reg_wd     (reg_wd),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .retire     (retire)
  );

  mips_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .ra1      (ra1),
    .ra2      (ra2),
    .dbg_addr (dbg_addr),
    .rd1      (rd1),
    .rd2      (rd2),
    .dbg_data (dbg_data),
    .we       (reg_we),
    .wa       (reg_wa),
    .wd       (reg_wd)
  );

  mips_data_mem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_data_mem (
    .clk   (clk),
    .addr  (dmem_addr),
    .wdata (dmem_wdata),
    .we    (dmem_we),
    .rdata (dmem_rdata)
  );

  // one instruction retires every running cycle
  assign retire_valid = run;

endmodule

`default_nettype wire

/* tests/mips_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_checker
  import mips_isa_pkg::*;
  import mips_cpu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    retire_valid,
  input  retire_t retire,
  output int      error_count
);

  // reference state of the architecture
  word_t model_pc;
  word_t model_regs [32];
  word_t model_mem [int];

  initial error_count = 0;

  task automatic mismatch(input string what, input word_t got, input word_t exp);
    $display("error at %0t: %s at pc %h, got %h expected %h",
             $time, what, model_pc, got, exp);
    error_count++;
  endtask

  task automatic step_model();
    word_t     ins;
    word_t     a;
    word_t     b;
    word_t     imm_ext;
    word_t     exp_data;
    word_t     exp_addr;
    word_t     next_pc;
    logic      exp_rwe;
    logic      exp_mwe;
    reg_addr_t exp_wa;
    ins      = retire.instr;
    a        = model_regs[ins[25:21]];
    b        = model_regs[ins[20:16]];
    imm_ext  = {{16{ins[15]}}, ins[15:0]};
    exp_rwe  = 1'b0;
    exp_mwe  = 1'b0;
    exp_wa   = ins[20:16];
    exp_data = '0;
    exp_addr = a + imm_ext;
    next_pc  = model_pc + 32'd4;
    case (opcode_t'(ins[31:26]))
      OP_RTYPE: begin
        exp_wa  = ins[15:11];
        exp_rwe = 1'b1;
        case (funct_t'(ins[5:0]))
          FN_ADD:  exp_data = a + b;
          FN_SUB:  exp_data = a - b;
          FN_AND:  exp_data = a & b;
          FN_OR:   exp_data = a | b;
          FN_SLT:  exp_data = {31'd0, $signed(a) < $signed(b)};
          default: exp_rwe = 1'b0;
        endcase
      end
      OP_ADDI: begin
        exp_rwe  = 1'b1;
        exp_data = exp_addr;
      end
      OP_LW: begin
        exp_rwe = 1'b1;
        if (model_mem.exists(exp_addr[31:2])) begin
          exp_data = model_mem[exp_addr[31:2]];
        end else begin
          $display("load at time %0t reads address %h that was never stored", $time, exp_addr);
          error_count++;
        end
      end
      OP_SW:   exp_mwe = 1'b1;
      OP_BEQ: begin
        if (a == b) next_pc = model_pc + 32'd4 + (imm_ext << 2);
      end
      default: ;
    endcase
    if (retire.pc !== model_pc) mismatch("pc", retire.pc, model_pc);
    if (retire.reg_we !== exp_rwe) mismatch("reg_we", 32'(retire.reg_we), 32'(exp_rwe));
    if (exp_rwe && retire.reg_addr !== exp_wa) mismatch("reg_addr", 32'(retire.reg_addr), 32'(exp_wa));
    if (exp_rwe && retire.reg_data !== exp_data) mismatch("reg_data", retire.reg_data, exp_data);
    if (retire.mem_we !== exp_mwe) mismatch("mem_we", 32'(retire.mem_we), 32'(exp_mwe));
    if (exp_mwe && retire.mem_addr !== exp_addr) mismatch("mem_addr", retire.mem_addr, exp_addr);
    // r0 stays zero in the model too
    if (exp_rwe && exp_wa != '0) model_regs[exp_wa] = exp_data;
    if (exp_mwe) model_mem[exp_addr[31:2]] = b;
    model_pc = next_pc;
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_pc = '0;
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      model_mem.delete();
    end else if (retire_valid) begin
      step_model();
    end
  end

endmodule

`default_nettype wire

/* tests/mips_top_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module mips_top_tb
  import mips_isa_pkg::*;
  import mips_cpu_pkg::*;
();

  localparam int IMEM_WORDS   = 64;
  localparam int NUM_TESTS    = 6;
  localparam int PROG_LEN     = 8;
  localparam int MAX_CHECKS   = 6;
  localparam int PAUSE_CYCLES = 4;

  logic                          clk;
  logic                          rst_n;
  logic                          run;
  logic                          imem_we;
  logic [$clog2(IMEM_WORDS)-1:0] imem_addr;
  word_t                         imem_data;
  reg_addr_t                     dbg_addr;
  word_t                         dbg_data;
  logic                          retire_valid;
  retire_t                       retire;
  int                            chk_errors;
  int                            step_count;
  int                            pass_count;
  int                            fail_count;
  bit                            timed_out;

  // test table, one row per program
  word_t     prog     [NUM_TESTS][PROG_LEN];
  int        steps    [NUM_TESTS];
  int        pause_at [NUM_TESTS];
  reg_addr_t hold_reg [NUM_TESTS];
  int        num_chk  [NUM_TESTS];
  reg_addr_t chk_reg  [NUM_TESTS][MAX_CHECKS];
  word_t     chk_val  [NUM_TESTS][MAX_CHECKS];

  mips_top #(
    .IMEM_WORDS (IMEM_WORDS),
    .DMEM_WORDS (64)
  ) dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  mips_checker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .retire_valid (retire_valid),
    .retire       (retire),
    .error_count  (chk_errors)
  );

  always #5 clk = ~clk;

  // instructions retired since reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) step_count <= 0;
    else if (retire_valid) step_count <= step_count + 1;
  end

  function automatic word_t enc_r(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_i(opcode_t op, reg_addr_t rt, reg_addr_t rs, imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic fill_table();
    // r-type arithmetic with a negative operand
    prog[0] = '{enc_i(OP_ADDI, 1, 0, 12), enc_i(OP_ADDI, 2, 0, -5), enc_r(FN_ADD, 3, 1, 2),
                enc_r(FN_SUB, 4, 1, 2), enc_r(FN_AND, 5, 1, 2), enc_r(FN_OR, 6, 1, 2),
                enc_r(FN_SLT, 7, 2, 1), enc_r(FN_SLT, 8, 1, 2)};
    chk_reg[0] = '{3, 4, 5, 6, 7, 8};
    chk_val[0] = '{32'd7, 32'd17, 32'd8, 32'hffffffff, 32'd1, 32'd0};
    // sign extended immediates
    prog[1] = '{enc_i(OP_ADDI, 1, 0, 100), enc_i(OP_ADDI, 2, 1, -1), enc_i(OP_ADDI, 3, 1, -200),
                enc_i(OP_ADDI, 4, 0, -32768), 32'd0, 32'd0, 32'd0, 32'd0};
    chk_reg[1] = '{2, 3, 4, 0, 0, 0};
    chk_val[1] = '{32'd99, 32'hffffff9c, 32'hffff8000, 32'd0, 32'd0, 32'd0};
    // store two words, load them back
    prog[2] = '{enc_i(OP_ADDI, 1, 0, 16), enc_i(OP_ADDI, 2, 0, 'h123), enc_i(OP_ADDI, 3, 0, -2),
                enc_i(OP_SW, 2, 1, 0), enc_i(OP_SW, 3, 1, 8), enc_i(OP_LW, 4, 1, 0),
                enc_i(OP_LW, 5, 1, 8), enc_r(FN_ADD, 6, 4, 5)};
    chk_reg[2] = '{4, 5, 6, 0, 0, 0};
    chk_val[2] = '{32'h123, 32'hfffffffe, 32'h121, 32'd0, 32'd0, 32'd0};
    // taken beq skips slot 3, second beq falls through
    prog[3] = '{enc_i(OP_ADDI, 1, 0, 5), enc_i(OP_ADDI, 2, 0, 5), enc_i(OP_BEQ, 2, 1, 1),
                enc_i(OP_ADDI, 3, 0, 99), enc_i(OP_ADDI, 4, 0, 1), enc_i(OP_BEQ, 0, 1, 1),
                enc_i(OP_ADDI, 5, 0, 2), enc_i(OP_ADDI, 6, 0, 3)};
    chk_reg[3] = '{3, 4, 5, 6, 0, 0};
    chk_val[3] = '{32'd0, 32'd1, 32'd2, 32'd3, 32'd0, 32'd0};
    // writes to r0 are dropped
    prog[4] = '{enc_i(OP_ADDI, 0, 0, 55), enc_i(OP_ADDI, 1, 0, 9), enc_r(FN_ADD, 0, 1, 1),
                enc_r(FN_ADD, 2, 0, 1), 32'd0, 32'd0, 32'd0, 32'd0};
    chk_reg[4] = '{0, 1, 2, 0, 0, 0};
    chk_val[4] = '{32'd0, 32'd9, 32'd9, 32'd0, 32'd0, 32'd0};
    // stopped after two instructions, then resumed
    prog[5] = '{enc_i(OP_ADDI, 1, 0, 3), enc_i(OP_ADDI, 2, 1, 4), enc_r(FN_ADD, 3, 1, 2),
                enc_r(FN_SUB, 4, 3, 1), enc_r(FN_OR, 5, 1, 2), 32'd0, 32'd0, 32'd0};
    chk_reg[5] = '{3, 4, 5, 0, 0, 0};
    chk_val[5] = '{32'd10, 32'd7, 32'd7, 32'd0, 32'd0, 32'd0};
    steps    = '{8, 4, 8, 7, 4, 5};
    pause_at = '{0, 0, 0, 0, 0, 2};
    // destination of the held instruction, still zero from reset
    hold_reg = '{0, 0, 0, 0, 0, 3};
    num_chk  = '{6, 3, 3, 4, 3, 3};
  endtask

  task automatic reset_and_load(input int t);
    rst_n = 1'b0;
    run   = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < PROG_LEN; i++) begin
      imem_we   = 1'b1;
      imem_addr = i;
      imem_data = prog[t][i];
      @(negedge clk);
    end
    imem_we = 1'b0;
  endtask

  // starts at a falling edge, stops the core once target is reached
  task automatic run_until(input int target, output bit ok);
    int waited;
    waited = 0;
    run = 1'b1;
    while (step_count < target && waited < target + 16) begin
      @(negedge clk);
      waited++;
    end
    run = 1'b0;
    ok  = (step_count == target);
  endtask

  task automatic check_regs(input int t, inout int bad);
    for (int i = 0; i < num_chk[t]; i++) begin
      dbg_addr = chk_reg[t][i];
      @(posedge clk);
      if (dbg_data !== chk_val[t][i]) begin
        $display("error at %0t: test %0d r%0d got %h expected %h",
                 $time, t, chk_reg[t][i], dbg_data, chk_val[t][i]);
        bad++;
      end
      @(negedge clk);
    end
  endtask

  task automatic run_test(input int t);
    int    bad;
    int    errs_before;
    bit    ok;
    word_t held_pc;
    bad = 0;
    ok  = 1'b1;
    reset_and_load(t);
    errs_before = chk_errors;
    if (pause_at[t] > 0) begin
      run_until(pause_at[t], ok);
      held_pc  = retire.pc;
      dbg_addr = hold_reg[t];
      repeat (PAUSE_CYCLES) @(negedge clk);
      if (retire.pc !== held_pc || held_pc !== word_t'(4 * pause_at[t])) begin
        $display("error at %0t: test %0d pc %h moved while stopped", $time, t, retire.pc);
        bad++;
      end
      if (dbg_data !== '0) begin
        $display("error at %0t: test %0d r%0d written while stopped, got %h",
                 $time, t, hold_reg[t], dbg_data);
        bad++;
      end
    end
    if (ok) run_until(steps[t], ok);
    if (!ok) begin
      $display("test %0d timed out waiting for %0d instructions to retire", t, steps[t]);
      timed_out = 1'b1;
    end else begin
      check_regs(t, bad);
    end
    bad += chk_errors - errs_before;
    if (ok && bad == 0) pass_count++;
    else fail_count++;
    $display("test %0d %s, %0d errors", t, (ok && bad == 0) ? "passed" : "failed", bad);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_data  = '0;
    dbg_addr   = '0;
    pass_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;
    fill_table();
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d, checker errors %0d",
             pass_count, fail_count, chk_errors);
    if (timed_out || fail_count != 0) $display("Simulation failed");
    else $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
